// ==== Makefile ====
TOP := mmu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "sim failed" sim.log; then \
		echo "failure reported in sim.log"; \
		exit 1; \
	fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
mmu_pkg.sv
dtlb.sv
pte_perm_check.sv
ld_st_translate.sv
mmu_top.sv
tb_clk_gen.sv
mmu_tb.sv

// ==== dtlb.sv ====
// Fully associative data TLB
`timescale 1ns/1ps

module dtlb import mmu_pkg::*; #(
    parameter int unsigned TLB_ENTRIES = 4,
    parameter int unsigned ASID_WIDTH  = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // lookup
    input  vaddr_t                lu_vaddr_i,
    input  logic [ASID_WIDTH-1:0] lu_asid_i,
    output logic                  lu_hit_o,
    output logic [PPNW-1:0]       lu_ppn_o,
    output logic                  lu_is_2m_o,
    output logic                  lu_is_1g_o,
    output logic                  lu_u_o,
    output logic                  lu_w_o,
    output logic                  lu_d_o,
    // refill
    input  logic                  refill_i,
    input  logic [ASID_WIDTH-1:0] refill_asid_i,
    input  vaddr_t                refill_vaddr_i,
    input  logic [PPNW-1:0]       refill_ppn_i,
    input  logic                  refill_is_2m_i,
    input  logic                  refill_is_1g_i,
    input  logic                  refill_u_i,
    input  logic                  refill_w_i,
    input  logic                  refill_d_i,
    // flush
    input  logic                  flush_tlb_i,
    input  logic [ASID_WIDTH-1:0] flush_asid_i,
    input  vaddr_t                flush_vaddr_i,
    input  logic                  flush_by_asid_i,
    input  logic                  flush_by_vaddr_i
);

    localparam int unsigned IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    // tags
    logic [TLB_ENTRIES-1:0]  valid_q;
    logic [ASID_WIDTH-1:0]   asid_q [TLB_ENTRIES];
    logic [VPN_W-1:0]        vpn2_q [TLB_ENTRIES];
    logic [VPN_W-1:0]        vpn1_q [TLB_ENTRIES];
    logic [VPN_W-1:0]        vpn0_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0]  is_2m_q;
    logic [TLB_ENTRIES-1:0]  is_1g_q;
    // content
    logic [PPNW-1:0]         ppn_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0]  u_q;
    logic [TLB_ENTRIES-1:0]  w_q;
    logic [TLB_ENTRIES-1:0]  d_q;

    logic [TLB_ENTRIES-1:0]  lu_match;
    logic [TLB_ENTRIES-1:0]  flush_match;
    logic [IDX_W-1:0]        rr_q;
    logic [IDX_W-1:0]        victim;
    logic                    refill_en;

    // vpn compare, lower levels ignored for superpages
    function automatic logic page_match(
        input vaddr_t           va,
        input logic [VPN_W-1:0] v2,
        input logic [VPN_W-1:0] v1,
        input logic [VPN_W-1:0] v0,
        input logic             sp_2m,
        input logic             sp_1g
    );
        page_match = (va.vpn.vpn2 == v2)
                   && (sp_1g || va.vpn.vpn1 == v1)
                   && (sp_1g || sp_2m || va.vpn.vpn0 == v0);
    endfunction

    // ------------------------------
    // lookup and flush match
    // ------------------------------
    always_comb begin
        lu_hit_o   = 1'b0;
        lu_ppn_o   = '0;
        lu_is_2m_o = 1'b0;
        lu_is_1g_o = 1'b0;
        lu_u_o     = 1'b0;
        lu_w_o     = 1'b0;
        lu_d_o     = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            lu_match[i] = valid_q[i] && (asid_q[i] == lu_asid_i)
                        && page_match(lu_vaddr_i, vpn2_q[i], vpn1_q[i], vpn0_q[i],
                                      is_2m_q[i], is_1g_q[i]);
            // neither flag set means every entry goes
            flush_match[i] = (!flush_by_asid_i || asid_q[i] == flush_asid_i)
                           && (!flush_by_vaddr_i
                               || page_match(flush_vaddr_i, vpn2_q[i], vpn1_q[i],
                                             vpn0_q[i], is_2m_q[i], is_1g_q[i]));
            if (lu_match[i]) begin
                lu_hit_o   = 1'b1;
                lu_ppn_o   = ppn_q[i];
                lu_is_2m_o = is_2m_q[i];
                lu_is_1g_o = is_1g_q[i];
                lu_u_o     = u_q[i];
                lu_w_o     = w_q[i];
                lu_d_o     = d_q[i];
            end
        end
    end

    // ------------------------------
    // replacement
    // ------------------------------
    // lowest invalid entry first, round robin once full
    always_comb begin
        victim = rr_q;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                victim = IDX_W'(i);
            end
        end
    end

    // a flush in the same cycle drops the refill
    assign refill_en = refill_i && !flush_tlb_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (flush_tlb_i) begin
            valid_q <= valid_q & ~flush_match;
        end else if (refill_en) begin
            valid_q[victim] <= 1'b1;
            // pointer only moves when it was the one that picked
            if (&valid_q) begin
                rr_q <= (rr_q == IDX_W'(TLB_ENTRIES - 1)) ? '0 : rr_q + 1'b1;
            end
        end
    end

    // entry write
    always_ff @(posedge clk_i) begin
        if (refill_en) begin
            asid_q[victim]  <= refill_asid_i;
            vpn2_q[victim]  <= refill_vaddr_i.vpn.vpn2;
            vpn1_q[victim]  <= refill_vaddr_i.vpn.vpn1;
            vpn0_q[victim]  <= refill_vaddr_i.vpn.vpn0;
            is_2m_q[victim] <= refill_is_2m_i;
            is_1g_q[victim] <= refill_is_1g_i;
            ppn_q[victim]   <= refill_ppn_i;
            u_q[victim]     <= refill_u_i;
            w_q[victim]     <= refill_w_i;
            d_q[victim]     <= refill_d_i;
        end
    end

endmodule

// ==== ld_st_translate.sv ====
// Load/store translation stage
`timescale 1ns/1ps

module ld_st_translate import mmu_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             en_translation_i,
    // request
    input  logic             lsu_req_i,
    input  vaddr_t           lsu_vaddr_i,
    input  logic             lsu_is_store_i,
    input  logic             misaligned_i,
    // tlb results
    input  logic             dtlb_hit_i,
    input  logic [PPNW-1:0]  dtlb_ppn_i,
    input  logic             dtlb_is_2m_i,
    input  logic             dtlb_is_1g_i,
    input  logic             dtlb_u_i,
    input  logic             dtlb_w_i,
    input  logic             dtlb_d_i,
    // permission check
    input  logic             page_fault_i,
    output logic             pte_u_q_o,
    output logic             pte_w_q_o,
    output logic             pte_d_q_o,
    output logic             is_store_q_o,
    // cycle 0
    output logic             lsu_dtlb_hit_o,
    output logic [PPNW-1:0]  lsu_dtlb_ppn_o,
    output logic             dtlb_miss_o,
    // cycle 1
    output logic             lsu_valid_o,
    output logic [PLEN-1:0]  lsu_paddr_o,
    output logic             lsu_ex_valid_o,
    output logic [5:0]       lsu_ex_cause_o,
    output logic [XLEN-1:0]  lsu_ex_tval_o
);

    logic [PPNW-1:0] ppn_xlat;
    logic [PLEN-1:0] paddr_d;
    logic            misaligned_d;

    vaddr_t          vaddr_q;
    logic            req_q;
    logic            hit_q;
    logic            misaligned_q;

    // ------------------------------
    // cycle 0
    // ------------------------------
    // superpages take the lower vpn levels straight from the vaddr
    always_comb begin
        ppn_xlat = dtlb_ppn_i;
        if (dtlb_is_2m_i) begin
            ppn_xlat[8:0] = lsu_vaddr_i.raw[20:12];
        end
        if (dtlb_is_1g_i) begin
            ppn_xlat[17:0] = lsu_vaddr_i.raw[29:12];
        end
    end

    // bare mode passes the vaddr through, zero extended
    assign paddr_d = en_translation_i ? {ppn_xlat, lsu_vaddr_i.vpn.offset}
                                      : {{(PLEN - VLEN){1'b0}}, lsu_vaddr_i.raw};

    assign lsu_dtlb_hit_o = en_translation_i ? dtlb_hit_i : 1'b1;
    assign lsu_dtlb_ppn_o = paddr_d[PLEN-1:PAGE_OFFSET_W];
    assign dtlb_miss_o    = lsu_req_i && en_translation_i && !dtlb_hit_i;

    // no request, no misaligned exception
    assign misaligned_d = misaligned_i && lsu_req_i;

    // ------------------------------
    // stage registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vaddr_q      <= '0;
            req_q        <= 1'b0;
            hit_q        <= 1'b0;
            misaligned_q <= 1'b0;
            is_store_q_o <= 1'b0;
            pte_u_q_o    <= 1'b0;
            pte_w_q_o    <= 1'b0;
            pte_d_q_o    <= 1'b0;
            lsu_paddr_o  <= '0;
        end else begin
            vaddr_q      <= lsu_vaddr_i;
            req_q        <= lsu_req_i;
            hit_q        <= dtlb_hit_i;
            misaligned_q <= misaligned_d;
            is_store_q_o <= lsu_is_store_i;
            pte_u_q_o    <= dtlb_u_i;
            pte_w_q_o    <= dtlb_w_i;
            pte_d_q_o    <= dtlb_d_i;
            lsu_paddr_o  <= paddr_d;
        end
    end

    // ------------------------------
    // cycle 1 result
    // ------------------------------
    always_comb begin
        lsu_valid_o    = req_q;
        lsu_ex_valid_o = 1'b0;
        lsu_ex_cause_o = '0;
        lsu_ex_tval_o  = '0;
        if (misaligned_q) begin
            // misaligned is answered whether or not the tlb hit
            lsu_ex_valid_o = 1'b1;
            lsu_ex_cause_o = is_store_q_o ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
            lsu_ex_tval_o  = {{(XLEN - VLEN){1'b0}}, vaddr_q.raw};
        end else if (en_translation_i) begin
            // a miss stays silent until refill and reissue
            lsu_valid_o = req_q && hit_q;
            if (req_q && hit_q && page_fault_i) begin
                lsu_ex_valid_o = 1'b1;
                lsu_ex_cause_o = is_store_q_o ? CAUSE_ST_PAGE_FAULT : CAUSE_LD_PAGE_FAULT;
                lsu_ex_tval_o  = {{(XLEN - VLEN){vaddr_q.raw[VLEN-1]}}, vaddr_q.raw};
            end
        end
    end

endmodule

// ==== mmu_pkg.sv ====
// Sv39 MMU shared definitions
package mmu_pkg;

    // ------------------------------
    // address widths
    // ------------------------------
    // sv39 virtual address
    localparam int unsigned VLEN = 39;
    // physical address and page number
    localparam int unsigned PLEN = 56;
    localparam int unsigned PPNW = 44;
    // exception value width, one full register
    localparam int unsigned XLEN = 64;
    // 4 KiB page offset
    localparam int unsigned PAGE_OFFSET_W = 12;
    // each of the three page-table levels indexes 512 entries
    localparam int unsigned VPN_W = 9;

    // ------------------------------
    // privilege levels
    // ------------------------------
    localparam logic [1:0] PRIV_LVL_U = 2'd0;
    localparam logic [1:0] PRIV_LVL_S = 2'd1;

    // ------------------------------
    // exception causes
    // ------------------------------
    localparam logic [5:0] CAUSE_LD_MISALIGNED = 6'd4;
    localparam logic [5:0] CAUSE_ST_MISALIGNED = 6'd6;
    localparam logic [5:0] CAUSE_LD_PAGE_FAULT = 6'd13;
    localparam logic [5:0] CAUSE_ST_PAGE_FAULT = 6'd15;

    // virtual address, read either as one word or split into
    // the three vpn levels and the page offset
    typedef union packed {
        logic [VLEN-1:0] raw;
        struct packed {
            logic [VPN_W-1:0]         vpn2;
            logic [VPN_W-1:0]         vpn1;
            logic [VPN_W-1:0]         vpn0;
            logic [PAGE_OFFSET_W-1:0] offset;
        } vpn;
    } vaddr_t;

endpackage

// ==== mmu_tb.sv ====
// Data MMU testbench
`timescale 1ns/1ps

module mmu_tb import mmu_pkg::*; ();

    localparam int TLB_N         = 4;
    localparam int ASID_W        = 4;
    localparam int CLK_PERIOD_NS = 8;
    localparam int RESET_CYCLES  = 10;
    localparam int NUM_CYCLES    = 4000;
    localparam int WATCHDOG_NS   = (NUM_CYCLES + RESET_CYCLES + 50) * CLK_PERIOD_NS;

    logic              clk;
    logic              rst_n;
    // configuration and request
    logic              en_translation;
    logic [1:0]        priv_lvl;
    logic              sum;
    logic [ASID_W-1:0] asid;
    logic              lsu_req;
    logic [VLEN-1:0]   lsu_vaddr;
    logic              lsu_is_store;
    logic              misaligned;
    // refill port
    logic              refill;
    logic [ASID_W-1:0] refill_asid;
    logic [VLEN-1:0]   refill_vaddr;
    logic [PPNW-1:0]   refill_ppn;
    logic              refill_is_2m;
    logic              refill_is_1g;
    logic              refill_u;
    logic              refill_w;
    logic              refill_d;
    // flush port
    logic              flush_tlb;
    logic [ASID_W-1:0] flush_asid;
    logic [VLEN-1:0]   flush_vaddr;
    logic              flush_by_asid;
    logic              flush_by_vaddr;
    // results
    logic              lsu_dtlb_hit;
    logic [PPNW-1:0]   lsu_dtlb_ppn;
    logic              lsu_valid;
    logic [PLEN-1:0]   lsu_paddr;
    logic              lsu_ex_valid;
    logic [5:0]        lsu_ex_cause;
    logic [XLEN-1:0]   lsu_ex_tval;
    logic              dtlb_miss;

    // ------------------------------
    // reference TLB
    // ------------------------------
    logic [TLB_N-1:0]  m_valid;
    logic [ASID_W-1:0] m_asid [TLB_N];
    vaddr_t            m_va [TLB_N];
    logic [PPNW-1:0]   m_ppn [TLB_N];
    logic [TLB_N-1:0]  m_2m;
    logic [TLB_N-1:0]  m_1g;
    logic [TLB_N-1:0]  m_u;
    logic [TLB_N-1:0]  m_w;
    logic [TLB_N-1:0]  m_d;
    int                m_rr;
    // page pool, one gigapage region per slot
    vaddr_t            pool [8];
    logic [31:0]       rng;
    int                err_cnt;
    int                check_cnt;
    // cycle 1 expectation of the request in flight
    logic              e_valid;
    logic              e_ex;
    logic              e_paddr_chk;
    logic [5:0]        e_cause;
    logic [XLEN-1:0]   e_tval;
    logic [PLEN-1:0]   e_paddr;

    tb_clk_gen #(
        .PERIOD_NS    ( CLK_PERIOD_NS ),
        .RESET_CYCLES ( RESET_CYCLES  )
    ) i_clk_gen (
        .clk_o  ( clk   ),
        .rst_no ( rst_n )
    );

    mmu_top #(
        .TLB_ENTRIES ( TLB_N  ),
        .ASID_WIDTH  ( ASID_W )
    ) uut (
        .clk_i            ( clk            ),
        .rst_ni           ( rst_n          ),
        .en_translation_i ( en_translation ),
        .priv_lvl_i       ( priv_lvl       ),
        .sum_i            ( sum            ),
        .asid_i           ( asid           ),
        .lsu_req_i        ( lsu_req        ),
        .lsu_vaddr_i      ( lsu_vaddr      ),
        .lsu_is_store_i   ( lsu_is_store   ),
        .misaligned_i     ( misaligned     ),
        .refill_i         ( refill         ),
        .refill_asid_i    ( refill_asid    ),
        .refill_vaddr_i   ( refill_vaddr   ),
        .refill_ppn_i     ( refill_ppn     ),
        .refill_is_2m_i   ( refill_is_2m   ),
        .refill_is_1g_i   ( refill_is_1g   ),
        .refill_u_i       ( refill_u       ),
        .refill_w_i       ( refill_w       ),
        .refill_d_i       ( refill_d       ),
        .flush_tlb_i      ( flush_tlb      ),
        .flush_asid_i     ( flush_asid     ),
        .flush_vaddr_i    ( flush_vaddr    ),
        .flush_by_asid_i  ( flush_by_asid  ),
        .flush_by_vaddr_i ( flush_by_vaddr ),
        .lsu_dtlb_hit_o   ( lsu_dtlb_hit   ),
        .lsu_dtlb_ppn_o   ( lsu_dtlb_ppn   ),
        .lsu_valid_o      ( lsu_valid      ),
        .lsu_paddr_o      ( lsu_paddr      ),
        .lsu_ex_valid_o   ( lsu_ex_valid   ),
        .lsu_ex_cause_o   ( lsu_ex_cause   ),
        .lsu_ex_tval_o    ( lsu_ex_tval    ),
        .dtlb_miss_o      ( dtlb_miss      )
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_bit(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch %s: expected %h, got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_ppn(input logic [PPNW-1:0] exp, input logic [PPNW-1:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch lsu_dtlb_ppn_o: expected %h, got %h at %0t", exp, act, $time);
        end
    endtask

    task automatic check_paddr(input logic [PLEN-1:0] exp, input logic [PLEN-1:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch lsu_paddr_o: expected %h, got %h at %0t", exp, act, $time);
        end
    endtask

    task automatic check_cause(input logic [5:0] exp, input logic [5:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch lsu_ex_cause_o: expected %h, got %h at %0t", exp, act, $time);
        end
    endtask

    task automatic check_tval(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch lsu_ex_tval_o: expected %h, got %h at %0t", exp, act, $time);
        end
    endtask

    // ------------------------------
    // model helpers
    // ------------------------------
    // lower levels are don't care inside a superpage
    function automatic logic covers_page(input vaddr_t tag, input logic sp_2m,
                                         input logic sp_1g, input vaddr_t va);
        logic same2;
        logic same1;
        logic same0;
        same2 = tag.vpn.vpn2 == va.vpn.vpn2;
        same1 = tag.vpn.vpn1 == va.vpn.vpn1;
        same0 = tag.vpn.vpn0 == va.vpn.vpn0;
        return same2 && (sp_1g || same1) && (sp_1g || sp_2m || same0);
    endfunction

    // index of the hitting entry, -1 on a miss
    function automatic int lookup(input logic [ASID_W-1:0] a, input vaddr_t va);
        int idx;
        idx = -1;
        for (int i = 0; i < TLB_N; i++) begin
            if (m_valid[i] && m_asid[i] == a && covers_page(m_va[i], m_2m[i], m_1g[i], va)) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // any valid entry of this asid in the same gigapage region
    function automatic logic region_mapped(input logic [ASID_W-1:0] a, input vaddr_t va);
        logic found;
        found = 1'b0;
        for (int i = 0; i < TLB_N; i++) begin
            if (m_valid[i] && m_asid[i] == a && m_va[i].vpn.vpn2 == va.vpn.vpn2) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic drive_inputs();
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] r3;
        vaddr_t      va;
        r  = next_rand();
        r2 = next_rand();
        en_translation = r[1:0] != 2'b00;
        priv_lvl       = r[2] ? PRIV_LVL_S : PRIV_LVL_U;
        sum            = r[3];
        // asid changes only now and then, so refills get hit
        if (r[7:4] == 4'h0) begin
            asid = ASID_W'(r[9:8]);
        end
        lsu_req      = r[11:10] != 2'b00;
        lsu_is_store = r[12];
        misaligned   = r[15:13] == 3'b000;
        va = pool[r[18:16]];
        va.vpn.offset = r[31:20];
        // other 4K pages of the region, reached only by superpages
        if (r[19]) begin
            va.vpn.vpn0 = r2[8:0];
            if (r2[31]) begin
                va.vpn.vpn1 = r2[17:9];
            end
        end
        if (r2[30:28] == 3'b000) begin
            r3 = next_rand();
            va.raw = {r2[24:18], r3};
        end
        lsu_vaddr = va.raw;

        // refill, kept unambiguous by one entry per asid and region
        r  = next_rand();
        r2 = next_rand();
        va = pool[r[4:2]];
        refill_asid  = r[5] ? ASID_W'(r[7:6]) : asid;
        refill_is_2m = r[9:8] == 2'b01;
        refill_is_1g = r[9:8] == 2'b10;
        refill_u     = r[10];
        refill_w     = r[11];
        refill_d     = r[12];
        refill_ppn   = {r[31:20], r2};
        refill_vaddr = va.raw;
        refill       = r[1:0] == 2'b00 && !region_mapped(refill_asid, va);

        r  = next_rand();
        va = pool[r[12:10]];
        if (r[13]) begin
            va.vpn.vpn0 = r[22:14];
        end
        flush_tlb      = r[5:0] == 6'd0;
        flush_by_asid  = r[6];
        flush_by_vaddr = r[7];
        flush_asid     = ASID_W'(r[9:8]);
        flush_vaddr    = va.raw;
    endtask

    // cycle 0 outputs, then the expectation for the next cycle
    task automatic check_cycle0();
        vaddr_t          va;
        int              idx;
        logic [PPNW-1:0] ppn;
        logic [PLEN-1:0] paddr;
        logic            fault;
        va    = lsu_vaddr;
        idx   = lookup(asid, va);
        ppn   = '0;
        fault = 1'b0;
        if (idx >= 0) begin
            ppn = m_ppn[idx];
            if (m_2m[idx]) begin
                ppn[8:0] = va.raw[20:12];
            end
            if (m_1g[idx]) begin
                ppn[17:0] = va.raw[29:12];
            end
            fault = (priv_lvl == PRIV_LVL_S && !sum && m_u[idx])
                 || (priv_lvl == PRIV_LVL_U && !m_u[idx])
                 || (lsu_is_store && (!m_w[idx] || !m_d[idx]));
        end
        if (en_translation) begin
            paddr = {ppn, va.vpn.offset};
        end else begin
            paddr = PLEN'(va.raw);
        end
        check_bit("lsu_dtlb_hit_o", !en_translation || idx >= 0, lsu_dtlb_hit);
        check_bit("dtlb_miss_o", lsu_req && en_translation && idx < 0, dtlb_miss);
        if (!en_translation || idx >= 0) begin
            check_ppn(paddr[PLEN-1:PAGE_OFFSET_W], lsu_dtlb_ppn);
        end

        e_paddr     = paddr;
        e_paddr_chk = !en_translation || idx >= 0;
        e_ex        = 1'b0;
        e_cause     = '0;
        e_tval      = '0;
        if (lsu_req && misaligned) begin
            e_valid = 1'b1;
            e_ex    = 1'b1;
            e_cause = lsu_is_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
            e_tval  = {{(XLEN - VLEN){1'b0}}, va.raw};
        end else if (en_translation) begin
            e_valid = lsu_req && idx >= 0;
            if (e_valid && fault) begin
                e_ex    = 1'b1;
                e_cause = lsu_is_store ? CAUSE_ST_PAGE_FAULT : CAUSE_LD_PAGE_FAULT;
                e_tval  = {{(XLEN - VLEN){va.raw[VLEN-1]}}, va.raw};
            end
        end else begin
            e_valid = lsu_req;
        end
    endtask

    task automatic check_cycle1();
        check_bit("lsu_valid_o", e_valid, lsu_valid);
        check_bit("lsu_ex_valid_o", e_ex, lsu_ex_valid);
        if (e_valid && e_paddr_chk) begin
            check_paddr(e_paddr, lsu_paddr);
        end
        if (e_ex) begin
            check_cause(e_cause, lsu_ex_cause);
            check_tval(e_tval, lsu_ex_tval);
        end
    endtask

    // what the coming edge does to the TLB, flush before refill
    task automatic update_model();
        int victim;
        if (flush_tlb) begin
            for (int i = 0; i < TLB_N; i++) begin
                if ((!flush_by_asid || m_asid[i] == flush_asid)
                    && (!flush_by_vaddr
                        || covers_page(m_va[i], m_2m[i], m_1g[i], flush_vaddr))) begin
                    m_valid[i] = 1'b0;
                end
            end
        end else if (refill) begin
            victim = -1;
            for (int i = TLB_N - 1; i >= 0; i--) begin
                if (!m_valid[i]) begin
                    victim = i;
                end
            end
            if (victim < 0) begin
                victim = m_rr;
                m_rr   = (m_rr + 1) % TLB_N;
            end
            m_valid[victim] = 1'b1;
            m_asid[victim]  = refill_asid;
            m_va[victim]    = refill_vaddr;
            m_ppn[victim]   = refill_ppn;
            m_2m[victim]    = refill_is_2m;
            m_1g[victim]    = refill_is_1g;
            m_u[victim]     = refill_u;
            m_w[victim]     = refill_w;
            m_d[victim]     = refill_d;
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        en_translation = 1'b0;
        priv_lvl       = PRIV_LVL_U;
        sum            = 1'b0;
        asid           = '0;
        lsu_req        = 1'b0;
        lsu_vaddr      = '0;
        lsu_is_store   = 1'b0;
        misaligned     = 1'b0;
        refill         = 1'b0;
        refill_asid    = '0;
        refill_vaddr   = '0;
        refill_ppn     = '0;
        refill_is_2m   = 1'b0;
        refill_is_1g   = 1'b0;
        refill_u       = 1'b0;
        refill_w       = 1'b0;
        refill_d       = 1'b0;
        flush_tlb      = 1'b0;
        flush_asid     = '0;
        flush_vaddr    = '0;
        flush_by_asid  = 1'b0;
        flush_by_vaddr = 1'b0;
        rng       = 32'h2b712a77;
        err_cnt   = 0;
        check_cnt = 0;
        m_valid   = '0;
        m_rr      = 0;
        e_valid   = 1'b0;
        e_ex      = 1'b0;
        // slot number in the low vpn2 bits keeps the regions apart
        for (int s = 0; s < 8; s++) begin
            r  = next_rand();
            r2 = next_rand();
            pool[s].raw      = {r[6:0], r2};
            pool[s].vpn.vpn2 = {r[12:7], 3'(s)};
        end

        @(posedge rst_n);
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(negedge clk);
            // inputs still hold the previous request here
            check_cycle1();
            drive_inputs();
            #1;
            check_cycle0();
            update_model();
        end
        @(negedge clk);
        check_cycle1();

        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the test loop did not complete", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== mmu_top.sv ====
// Sv39 data MMU top level
`timescale 1ns/1ps

module mmu_top import mmu_pkg::*; #(
    parameter int unsigned TLB_ENTRIES = 4,
    parameter int unsigned ASID_WIDTH  = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // configuration
    input  logic                  en_translation_i,
    input  logic [1:0]            priv_lvl_i,
    input  logic                  sum_i,
    input  logic [ASID_WIDTH-1:0] asid_i,
    // load/store request
    input  logic                  lsu_req_i,
    input  logic [VLEN-1:0]       lsu_vaddr_i,
    input  logic                  lsu_is_store_i,
    input  logic                  misaligned_i,
    // refill
    input  logic                  refill_i,
    input  logic [ASID_WIDTH-1:0] refill_asid_i,
    input  logic [VLEN-1:0]       refill_vaddr_i,
    input  logic [PPNW-1:0]       refill_ppn_i,
    input  logic                  refill_is_2m_i,
    input  logic                  refill_is_1g_i,
    input  logic                  refill_u_i,
    input  logic                  refill_w_i,
    input  logic                  refill_d_i,
    // flush
    input  logic                  flush_tlb_i,
    input  logic [ASID_WIDTH-1:0] flush_asid_i,
    input  logic [VLEN-1:0]       flush_vaddr_i,
    input  logic                  flush_by_asid_i,
    input  logic                  flush_by_vaddr_i,
    // results
    output logic                  lsu_dtlb_hit_o,
    output logic [PPNW-1:0]       lsu_dtlb_ppn_o,
    output logic                  lsu_valid_o,
    output logic [PLEN-1:0]       lsu_paddr_o,
    output logic                  lsu_ex_valid_o,
    output logic [5:0]            lsu_ex_cause_o,
    output logic [XLEN-1:0]       lsu_ex_tval_o,
    output logic                  dtlb_miss_o
);

    logic            tlb_hit;
    logic [PPNW-1:0] tlb_ppn;
    logic            tlb_is_2m;
    logic            tlb_is_1g;
    logic            tlb_u;
    logic            tlb_w;
    logic            tlb_d;
    // registered pte bits for the permission check
    logic            pte_u_q;
    logic            pte_w_q;
    logic            pte_d_q;
    logic            is_store_q;
    logic            page_fault;

    dtlb #(
        .TLB_ENTRIES ( TLB_ENTRIES ),
        .ASID_WIDTH  ( ASID_WIDTH  )
    ) i_dtlb (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .lu_vaddr_i       ( lsu_vaddr_i      ),
        .lu_asid_i        ( asid_i           ),
        .lu_hit_o         ( tlb_hit          ),
        .lu_ppn_o         ( tlb_ppn          ),
        .lu_is_2m_o       ( tlb_is_2m        ),
        .lu_is_1g_o       ( tlb_is_1g        ),
        .lu_u_o           ( tlb_u            ),
        .lu_w_o           ( tlb_w            ),
        .lu_d_o           ( tlb_d            ),
        .refill_i         ( refill_i         ),
        .refill_asid_i    ( refill_asid_i    ),
        .refill_vaddr_i   ( refill_vaddr_i   ),
        .refill_ppn_i     ( refill_ppn_i     ),
        .refill_is_2m_i   ( refill_is_2m_i   ),
        .refill_is_1g_i   ( refill_is_1g_i   ),
        .refill_u_i       ( refill_u_i       ),
        .refill_w_i       ( refill_w_i       ),
        .refill_d_i       ( refill_d_i       ),
        .flush_tlb_i      ( flush_tlb_i      ),
        .flush_asid_i     ( flush_asid_i     ),
        .flush_vaddr_i    ( flush_vaddr_i    ),
        .flush_by_asid_i  ( flush_by_asid_i  ),
        .flush_by_vaddr_i ( flush_by_vaddr_i )
    );

    ld_st_translate i_ld_st_translate (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .en_translation_i ( en_translation_i ),
        .lsu_req_i        ( lsu_req_i        ),
        .lsu_vaddr_i      ( lsu_vaddr_i      ),
        .lsu_is_store_i   ( lsu_is_store_i   ),
        .misaligned_i     ( misaligned_i     ),
        .dtlb_hit_i       ( tlb_hit          ),
        .dtlb_ppn_i       ( tlb_ppn          ),
        .dtlb_is_2m_i     ( tlb_is_2m        ),
        .dtlb_is_1g_i     ( tlb_is_1g        ),
        .dtlb_u_i         ( tlb_u            ),
        .dtlb_w_i         ( tlb_w            ),
        .dtlb_d_i         ( tlb_d            ),
        .page_fault_i     ( page_fault       ),
        .pte_u_q_o        ( pte_u_q          ),
        .pte_w_q_o        ( pte_w_q          ),
        .pte_d_q_o        ( pte_d_q          ),
        .is_store_q_o     ( is_store_q       ),
        .lsu_dtlb_hit_o   ( lsu_dtlb_hit_o   ),
        .lsu_dtlb_ppn_o   ( lsu_dtlb_ppn_o   ),
        .dtlb_miss_o      ( dtlb_miss_o      ),
        .lsu_valid_o      ( lsu_valid_o      ),
        .lsu_paddr_o      ( lsu_paddr_o      ),
        .lsu_ex_valid_o   ( lsu_ex_valid_o   ),
        .lsu_ex_cause_o   ( lsu_ex_cause_o   ),
        .lsu_ex_tval_o    ( lsu_ex_tval_o    )
    );

    // checks the pte captured in cycle 0 against the current privilege
    pte_perm_check i_pte_perm_check (
        .priv_lvl_i   ( priv_lvl_i ),
        .sum_i        ( sum_i      ),
        .pte_u_i      ( pte_u_q    ),
        .pte_w_i      ( pte_w_q    ),
        .pte_d_i      ( pte_d_q    ),
        .is_store_i   ( is_store_q ),
        .page_fault_o ( page_fault )
    );

endmodule

// ==== pte_perm_check.sv ====
// PTE permission check
`timescale 1ns/1ps

module pte_perm_check import mmu_pkg::*; (
    input  logic [1:0] priv_lvl_i,
    input  logic       sum_i,
    input  logic       pte_u_i,
    input  logic       pte_w_i,
    input  logic       pte_d_i,
    input  logic       is_store_i,
    output logic       page_fault_o
);

    logic priv_err;
    logic store_err;

    // supervisor may touch user pages only with SUM set,
    // user may never touch a supervisor page
    assign priv_err = ((priv_lvl_i == PRIV_LVL_S) && !sum_i && pte_u_i)
                   || ((priv_lvl_i == PRIV_LVL_U) && !pte_u_i);

    // stores need the page writable and already dirty
    assign store_err = is_store_i && (!pte_w_i || !pte_d_i);

    assign page_fault_o = priv_err || store_err;

endmodule

// ==== tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int unsigned PERIOD_NS    = 8,
    parameter int unsigned RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule
